//--- controlUnitTop.f
common/cuPkg.sv
decode/instDecoder.sv
hazard/operandForward.sv
hazard/hazardControl.sv
rtl/stageTracker.sv
rtl/controlUnitTop.sv
sim/controlUnit_chk.sv
sim/controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - common/cuPkg.sv
  - decode/instDecoder.sv
  - hazard/operandForward.sv
  - hazard/hazardControl.sv
  - rtl/stageTracker.sv
  - rtl/controlUnitTop.sv
  - target: simulation
    files:
      - sim/controlUnit_chk.sv
      - sim/controlUnitTb.sv

//--- sim/controlUnitTb.sv
`default_nettype none
`timescale 1ns/1ps

module controlUnitTb import cuPkg::*; ();

    localparam int numInst    = 2000;
    localparam int maxHold    = 1;     // Load-use stall is one cycle
    localparam int watchdogNs = 40000;

    typedef struct packed {
        exeCtrlT    ctrl;
        wbCtrlT     wb;
        pcSelT      pcSel;
        logic [1:0] used; // {rs2, rs1}
    } decodeT;

    logic       clk = 1'b0;
    logic       rstN;
    instFieldsT inst;
    logic       eq;
    logic       lt;
    exeCtrlT    exeCtrl;
    wbCtrlT     wbCtrl;
    pcSelT      pcSel;
    fwdSelT     qaSel;
    fwdSelT     qbSel;
    logic       pcStall;
    logic       ifidStall;
    logic       instNop;

    stageTagT   mExe;  // Model EXE tag
    stageTagT   mMem;  // Model MEM tag
    stageTagT   mNext; // Tag entering EXE at next edge
    logic [1:0] mHits; // Model load-use hits, {rs2, rs1}

    controlUnitTop u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .inst      (inst),
        .eq        (eq),
        .lt        (lt),
        .exeCtrl   (exeCtrl),
        .wbCtrl    (wbCtrl),
        .pcSel     (pcSel),
        .qaSel     (qaSel),
        .qbSel     (qbSel),
        .pcStall   (pcStall),
        .ifidStall (ifidStall),
        .instNop   (instNop)
    );

    always #2 clk = ~clk; // 4 ns period

    task automatic stopRun();
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkVal(input string name, input logic [15:0] expV, input logic [15:0] actV);
        if (expV !== actV) begin
            $display("mismatch %s: expected %0h actual %0h", name, expV, actV);
            stopRun();
        end
    endtask

    // Bound assertions sampled at the last edge
    task automatic checkAsserts();
        if (u_dut.uChk.failCount != 0) begin
            $display("Bound checker saw %0d failed assertions", u_dut.uChk.failCount);
            stopRun();
        end
    endtask

    // Reference decode table, written from the ISA
    function automatic decodeT refDecode(instFieldsT i);
        decodeT d;
        d = '0;
        d.ctrl.bType = {1'b0, i.funct3[2], i.funct3[0]};
        case (i.opcode)
            opRegArith, opImmArith: begin
                d.wb.wreg = 1'b1;
                d.used    = (i.opcode == opRegArith) ? 2'b11 : 2'b01;
                if (i.opcode == opImmArith) begin
                    d.ctrl.bSel = 2'h1; // immType I is 0
                end
                case (i.funct3)
                    3'b000: d.ctrl.aluc = (i.opcode == opRegArith && i.funct7[5]) ? 4'h1 : 4'h0;
                    3'b001: d.ctrl.aluc = 4'h5;
                    3'b100: d.ctrl.aluc = 4'h4;
                    3'b101: d.ctrl.aluc = i.funct7[5] ? 4'h7 : 4'h6;
                    3'b110: d.ctrl.aluc = 4'h3;
                    3'b111: d.ctrl.aluc = 4'h2;
                    3'b010: begin
                        d.ctrl.rSel       = 1'b1; // SLT
                        d.ctrl.signedComp = 1'b1;
                    end
                    default: d.ctrl.rSel = 1'b1; // SLTU
                endcase
            end
            opBranch: begin
                d.ctrl.aSel       = 1'b1;
                d.ctrl.bSel       = 2'h1;
                d.ctrl.immType    = 3'h2;
                d.ctrl.bType[2]   = 1'b1;
                d.ctrl.signedComp = (i.funct3[2:1] == 2'b10); // BLT, BGE
                d.used            = 2'b11;
            end
            opLoad: begin
                d.ctrl.bSel = 2'h1;
                d.wb.m2reg  = 1'b1;
                d.wb.wreg   = 1'b1;
                d.used      = 2'b01;
            end
            opStore: begin
                d.ctrl.bSel    = 2'h1;
                d.ctrl.immType = 3'h1;
                d.wb.wmem      = 1'b1;
                d.used         = 2'b11;
            end
            opLui, opAuipc: begin
                d.ctrl.aSel    = (i.opcode == opAuipc);
                d.ctrl.bSel    = 2'h1;
                d.ctrl.aluc    = (i.opcode == opLui) ? 4'hB : 4'h0;
                d.ctrl.immType = 3'h3;
                d.wb.wreg      = 1'b1;
            end
            opJal, opJalr: begin
                d.ctrl.aSel    = 1'b1;
                d.ctrl.bSel    = 2'h2; // Link value
                d.ctrl.immType = (i.opcode == opJal) ? 3'h4 : 3'h0;
                d.ctrl.isJalr  = (i.opcode == opJalr);
                d.wb.wreg      = 1'b1;
                d.pcSel        = 2'h1;
                d.used         = (i.opcode == opJalr) ? 2'b01 : 2'b00;
            end
            default: d.used = 2'b00; // NOP class
        endcase
        return d;
    endfunction

    // Weighted opcode mix, registers from a pool of four
    function automatic instFieldsT randInst();
        instFieldsT i;
        int         pick;
        pick     = $urandom_range(0, 99);
        i.rd     = regAddrT'($urandom_range(0, 3)); // x0 included
        i.rs1    = regAddrT'($urandom_range(0, 3));
        i.rs2    = regAddrT'($urandom_range(0, 3));
        i.funct3 = funct3T'($urandom_range(0, 7));
        i.funct7 = ($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0000000;
        if (pick < 14) i.opcode = opRegArith;
        else if (pick < 28) i.opcode = opImmArith;
        else if (pick < 44) i.opcode = opLoad;
        else if (pick < 54) i.opcode = opStore;
        else if (pick < 70) i.opcode = opBranch;
        else if (pick < 75) i.opcode = opLui;
        else if (pick < 80) i.opcode = opAuipc;
        else if (pick < 85) i.opcode = opJal;
        else if (pick < 90) i.opcode = opJalr;
        else if (pick < 94) i.opcode = pick[0] ? 7'b0111011 : 7'b0011011; // W opcodes
        else if (pick < 97) i.opcode = pick[0] ? 7'b0001111 : 7'b1110011; // FENCE, SYSTEM
        else i.opcode = opcodeT'($urandom_range(0, 127));
        return i;
    endfunction

    task automatic evalAndCheck(input string test);
        decodeT   d;
        regAddrT  src;
        fwdSelT   sel [2];
        logic     exeHit;
        logic     memHit;
        logic     taken;
        logic     stall;
        wbCtrlT   wb;
        pcSelT    pc;
        d = refDecode(inst);
        for (int k = 0; k < 2; k++) begin
            src    = (k == 0) ? inst.rs1 : inst.rs2;
            exeHit = mExe.wreg && (mExe.rd != 5'd0) && (mExe.rd == src);
            memHit = mMem.wreg && (mMem.rd != 5'd0) && (mMem.rd == src);
            if (exeHit && !mExe.m2reg) sel[k] = 2'd1;
            else if (memHit) sel[k] = mMem.m2reg ? 2'd3 : 2'd2;
            else sel[k] = 2'd0;
            mHits[k] = d.used[k] && exeHit && mExe.m2reg;
        end
        taken = (mExe.bType == 3'd4 && eq) || (mExe.bType == 3'd5 && !eq) ||
                (mExe.bType == 3'd6 && lt) || (mExe.bType == 3'd7 && !lt);
        stall = !taken && (mHits != 2'b00);
        wb    = d.wb;
        pc    = taken ? 2'd2 : d.pcSel;
        if (taken || stall) begin
            wb.wreg = 1'b0;
            wb.wmem = 1'b0;
        end
        checkVal({test, ".exeCtrl"}, d.ctrl, exeCtrl);
        checkVal({test, ".wbCtrl"}, wb, wbCtrl);
        checkVal({test, ".pcSel"}, pc, pcSel);
        checkVal({test, ".qaSel"}, sel[0], qaSel);
        checkVal({test, ".qbSel"}, sel[1], qbSel);
        checkVal({test, ".pcStall"}, stall, pcStall);
        checkVal({test, ".ifidStall"}, stall, ifidStall);
        checkVal({test, ".instNop"}, taken, instNop);
        mNext = '0; // Bubble on flush or stall
        if (!(taken || stall)) begin
            mNext.rd    = inst.rd;
            mNext.wreg  = wb.wreg;
            mNext.m2reg = wb.m2reg;
            mNext.bType = d.ctrl.bType;
        end
    endtask

    task automatic runCycle(input instFieldsT next, input string test);
        @(posedge clk);
        mMem = mExe; // Model advances with the DUT
        mExe = mNext;
        #1;
        inst = next;
        eq   = 1'($urandom_range(0, 1));
        lt   = 1'($urandom_range(0, 1));
        #1;
        evalAndCheck(test);
        checkAsserts();
    endtask

    initial begin
        #(watchdogNs);
        $display("Timeout: run did not finish within %0d ns", watchdogNs);
        stopRun();
    end

    initial begin
        instFieldsT cur;
        logic [1:0] hits;
        int         hold;
        rstN  = 1'b0;
        inst  = '0;
        eq    = 1'b0;
        lt    = 1'b0;
        mExe  = '0;
        mMem  = '0;
        mNext = '0;
        mHits = '0;
        void'($urandom(81340));
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        #1;
        checkVal("reset.pcStall", 16'd0, pcStall); // Tags empty after reset
        checkVal("reset.ifidStall", 16'd0, ifidStall);
        checkVal("reset.instNop", 16'd0, instNop);
        checkVal("reset.qaSel", 16'd0, qaSel);
        checkVal("reset.qbSel", 16'd0, qbSel);
        evalAndCheck("reset");
        for (int n = 0; n < numInst; n++) begin
            cur = randInst();
            runCycle(cur, "random");
            hold = 0;
            while (ifidStall === 1'b1) begin // Same inst again until ID takes it
                if (hold == maxHold) begin
                    $display("Load-use stall held ID for more than %0d cycle", maxHold);
                    stopRun();
                end
                hits = mHits;
                hold++;
                runCycle(cur, "retry");
                if (hits[0]) checkVal("retry.qaSelLoad", fwdMemLoad, qaSel);
                if (hits[1]) checkVal("retry.qbSelLoad", fwdMemLoad, qbSel);
            end
        end
        @(posedge clk); // Checker samples the last cycle
        #1;
        checkAsserts();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/controlUnit_chk.sv
`default_nettype none
`timescale 1ns/1ps

module controlUnitChk import cuPkg::*; (
    input logic   clk,
    input logic   rstN,
    input wbCtrlT wbCtrl,
    input logic   pcStall,
    input logic   ifidStall,
    input logic   instNop
);

    int failCount = 0; // Failed assertions so far

    // Both stalls come from one load-use decision
    stallPair: assert property (@(posedge clk) disable iff (!rstN)
        pcStall == ifidStall)
        else begin
            failCount++;
            $error("pcStall and ifidStall differ");
        end

    // Flush wins over stall
    nopNoStall: assert property (@(posedge clk) disable iff (!rstN)
        !(instNop && pcStall))
        else begin
            failCount++;
            $error("instNop and pcStall both high");
        end

    // Killed instruction must not write
    killNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        (pcStall || instNop) |-> (!wbCtrl.wreg && !wbCtrl.wmem))
        else begin
            failCount++;
            $error("write enable set on a killed instruction");
        end

endmodule

bind controlUnitTop controlUnitChk uChk (
    .clk       (clk),
    .rstN      (rstN),
    .wbCtrl    (wbCtrl),
    .pcStall   (pcStall),
    .ifidStall (ifidStall),
    .instNop   (instNop)
);

`default_nettype wire

//--- rtl/controlUnitTop.sv
`default_nettype none
`timescale 1ns/1ps

module controlUnitTop import cuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  instFieldsT inst,
    input  logic       eq,
    input  logic       lt,
    output exeCtrlT    exeCtrl,
    output wbCtrlT     wbCtrl,
    output pcSelT      pcSel,
    output fwdSelT     qaSel,
    output fwdSelT     qbSel,
    output logic       pcStall,
    output logic       ifidStall,
    output logic       instNop
);

    wbCtrlT     rawWb;
    pcSelT      rawPcSel;
    logic [1:0] srcUsed;
    logic [1:0] loadUseHit;
    logic       kill;
    regAddrT    srcReg [2];
    fwdSelT     fwdSel [2];
    stageTagT   idTag;
    stageTagT   exeTag;
    stageTagT   memTag;

    instDecoder uDecoder (
        .inst     (inst),
        .exeCtrl  (exeCtrl),
        .rawWb    (rawWb),
        .rawPcSel (rawPcSel),
        .srcUsed  (srcUsed)
    );

    assign srcReg[0] = inst.rs1;
    assign srcReg[1] = inst.rs2;

    // One forwarding slice per source operand
    for (genvar i = 0; i < 2; i++) begin : gFwd
        operandForward uFwd (
            .src        (srcReg[i]),
            .used       (srcUsed[i]),
            .exeTag     (exeTag),
            .memTag     (memTag),
            .fwdSel     (fwdSel[i]),
            .loadUseHit (loadUseHit[i])
        );
    end

    assign qaSel = fwdSel[0];
    assign qbSel = fwdSel[1];

    hazardControl uHazard (
        .rawWb      (rawWb),
        .rawPcSel   (rawPcSel),
        .loadUseHit (loadUseHit),
        .exeBType   (exeTag.bType),
        .eq         (eq),
        .lt         (lt),
        .wbCtrl     (wbCtrl),
        .pcSel      (pcSel),
        .pcStall    (pcStall),
        .ifidStall  (ifidStall),
        .instNop    (instNop),
        .kill       (kill)
    );

    // Final enables, so a killed instruction never forwards
    assign idTag = '{rd: inst.rd, wreg: wbCtrl.wreg, m2reg: wbCtrl.m2reg, bType: exeCtrl.bType};

    stageTracker uTracker (
        .clk    (clk),
        .rstN   (rstN),
        .kill   (kill),
        .idTag  (idTag),
        .exeTag (exeTag),
        .memTag (memTag)
    );

endmodule

`default_nettype wire

//--- rtl/stageTracker.sv
`default_nettype none
`timescale 1ns/1ps

module stageTracker import cuPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     kill,   // Flush or stall in ID
    input  stageTagT idTag,
    output stageTagT exeTag,
    output stageTagT memTag
);

    stageTagT nextExe;

    // Bubble has no write and no branch
    assign nextExe = kill ? stageTagT'('0) : idTag;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeTag <= '0;
            memTag <= '0;
        end else begin
            exeTag <= nextExe;
            memTag <= exeTag; // EXE always advances
        end
    end

endmodule

`default_nettype wire

//--- hazard/hazardControl.sv
`default_nettype none
`timescale 1ns/1ps

module hazardControl import cuPkg::*; (
    input  wbCtrlT     rawWb,
    input  pcSelT      rawPcSel,
    input  logic [1:0] loadUseHit, // {rs2, rs1}
    input  bTypeT      exeBType,
    input  logic       eq,         // EXE comparator
    input  logic       lt,
    output wbCtrlT     wbCtrl,
    output pcSelT      pcSel,
    output logic       pcStall,
    output logic       ifidStall,
    output logic       instNop,
    output logic       kill        // ID instruction becomes a bubble
);

    logic taken;
    logic stall;

    // Resolve the branch sitting in EXE
    always_comb begin
        case (exeBType)
            bTypeBeq: taken = eq;
            bTypeBne: taken = !eq;
            bTypeBlt: taken = lt;
            bTypeBge: taken = !lt;
            default:  taken = 1'b0; // Not a branch
        endcase
    end

    assign stall = |loadUseHit && !taken; // Flush beats stall

    always_comb begin
        wbCtrl = rawWb;
        pcSel  = rawPcSel;
        if (taken) begin
            wbCtrl.wreg = 1'b0;
            wbCtrl.wmem = 1'b0;
            pcSel       = pcBranch;
        end else if (stall) begin
            wbCtrl.wreg = 1'b0; // Retried next cycle
            wbCtrl.wmem = 1'b0;
        end
    end

    assign instNop   = taken;
    assign pcStall   = stall;
    assign ifidStall = stall;
    assign kill      = taken || stall;

endmodule

`default_nettype wire

//--- hazard/operandForward.sv
`default_nettype none
`timescale 1ns/1ps

module operandForward import cuPkg::*; (
    input  regAddrT  src,
    input  logic     used,   // Source actually read by the instruction
    input  stageTagT exeTag,
    input  stageTagT memTag,
    output fwdSelT   fwdSel,
    output logic     loadUseHit
);

    logic exeMatch;
    logic memMatch;

    // rd 0 is hardwired, never a producer
    assign exeMatch = exeTag.wreg && (exeTag.rd != '0) && (exeTag.rd == src);
    assign memMatch = memTag.wreg && (memTag.rd != '0) && (memTag.rd == src);

    always_comb begin
        if (exeMatch && !exeTag.m2reg) begin
            fwdSel = fwdExeAlu; // Youngest producer wins
        end else if (memMatch) begin
            fwdSel = memTag.m2reg ? fwdMemLoad : fwdMemAlu;
        end else begin
            fwdSel = fwdRegFile;
        end
    end

    // Load data not ready until MEM
    assign loadUseHit = used && exeMatch && exeTag.m2reg;

endmodule

`default_nettype wire

//--- decode/instDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module instDecoder import cuPkg::*; (
    input  instFieldsT inst,
    output exeCtrlT    exeCtrl,
    output wbCtrlT     rawWb,
    output pcSelT      rawPcSel,
    output logic [1:0] srcUsed // {rs2, rs1}
);

    logic isBranch;

    // Shared funct3 table for register and immediate arithmetic
    function automatic exeCtrlT arithCtrl(exeCtrlT base, funct3T f3, logic alt, logic allowSub);
        exeCtrlT c;
        c = base;
        case (f3)
            3'b000: c.aluc = (alt && allowSub) ? aluSub : aluAdd; // ADD, SUB, ADDI
            3'b111: c.aluc = aluAnd;
            3'b110: c.aluc = aluOr;
            3'b100: c.aluc = aluXor;
            3'b001: c.aluc = aluSll;
            3'b101: c.aluc = alt ? aluSra : aluSrl; // funct7[5] picks arithmetic
            3'b010: begin // SLT, SLTI
                c.rSel       = 1'b1;
                c.signedComp = 1'b1;
            end
            default: begin // SLTU, SLTIU
                c.rSel       = 1'b1;
                c.signedComp = 1'b0;
            end
        endcase
        return c;
    endfunction

    always_comb begin
        exeCtrl  = '0; // NOP unless overridden
        rawWb    = '0;
        rawPcSel = pcPlus4;
        srcUsed  = 2'b00;
        isBranch = 1'b0;
        case (inst.opcode)
            opRegArith: begin
                rawWb.wreg = 1'b1;
                srcUsed    = 2'b11;
                exeCtrl    = arithCtrl(exeCtrl, inst.funct3, inst.funct7[5], 1'b1);
            end
            opImmArith: begin
                exeCtrl.bSel    = 2'h1; // Immediate
                exeCtrl.immType = immI;
                rawWb.wreg      = 1'b1;
                srcUsed         = 2'b01;
                exeCtrl         = arithCtrl(exeCtrl, inst.funct3, inst.funct7[5], 1'b0);
            end
            opBranch: begin
                exeCtrl.aSel    = 1'b1; // PC + imm target
                exeCtrl.bSel    = 2'h1;
                exeCtrl.aluc    = aluAdd;
                exeCtrl.immType = immB;
                isBranch        = 1'b1;
                srcUsed         = 2'b11;
                case (inst.funct3)
                    3'b100, 3'b101: exeCtrl.signedComp = 1'b1; // BLT, BGE
                    default:        exeCtrl.signedComp = 1'b0; // BEQ, BNE, unsigned
                endcase
            end
            opLoad: begin
                exeCtrl.bSel    = 2'h1;
                exeCtrl.aluc    = aluAdd; // Address calc
                exeCtrl.immType = immI;
                rawWb.m2reg     = 1'b1;
                rawWb.wreg      = 1'b1;
                srcUsed         = 2'b01;
            end
            opStore: begin
                exeCtrl.bSel    = 2'h1;
                exeCtrl.aluc    = aluAdd;
                exeCtrl.immType = immS;
                rawWb.wmem      = 1'b1;
                srcUsed         = 2'b11; // rs2 is store data
            end
            opLui: begin
                exeCtrl.bSel    = 2'h1;
                exeCtrl.aluc    = aluLui;
                exeCtrl.immType = immU;
                rawWb.wreg      = 1'b1;
            end
            opAuipc: begin
                exeCtrl.aSel    = 1'b1;
                exeCtrl.bSel    = 2'h1;
                exeCtrl.aluc    = aluAdd;
                exeCtrl.immType = immU;
                rawWb.wreg      = 1'b1;
            end
            opJal: begin
                exeCtrl.aSel    = 1'b1;
                exeCtrl.bSel    = 2'h2; // PC + 4 link value
                exeCtrl.aluc    = aluAdd;
                exeCtrl.immType = immJ;
                rawWb.wreg      = 1'b1;
                rawPcSel        = pcJump;
            end
            opJalr: begin
                exeCtrl.aSel    = 1'b1;
                exeCtrl.bSel    = 2'h2;
                exeCtrl.aluc    = aluAdd;
                exeCtrl.immType = immI;
                exeCtrl.isJalr  = 1'b1; // Target from rs1
                rawWb.wreg      = 1'b1;
                rawPcSel        = pcJump;
                srcUsed         = 2'b01;
            end
            default: begin
                // FENCE, ECALL, EBREAK, W opcodes and unknowns stay a NOP
                isBranch = 1'b0;
            end
        endcase
        exeCtrl.bType = {isBranch, inst.funct3[2], inst.funct3[0]};
    end

endmodule

`default_nettype wire

//--- common/cuPkg.sv
`default_nettype none

package cuPkg;

    // Field widths fixed by the RV64I encoding
    localparam int regAddrW = 5;
    localparam int opcodeW  = 7;
    localparam int funct3W  = 3;
    localparam int funct7W  = 7;

    typedef logic [regAddrW-1:0] regAddrT;
    typedef logic [opcodeW-1:0]  opcodeT;
    typedef logic [funct3W-1:0]  funct3T;
    typedef logic [funct7W-1:0]  funct7T;
    typedef logic [3:0]          alucT;    // ALU operation
    typedef logic [2:0]          immTypeT; // Immediate format
    typedef logic [2:0]          bTypeT;   // {isBranch, funct3[2], funct3[0]}
    typedef logic [1:0]          fwdSelT;  // ID operand source
    typedef logic [1:0]          pcSelT;   // Next PC source

    // ALU codes
    localparam alucT aluAdd = 4'h0;
    localparam alucT aluSub = 4'h1;
    localparam alucT aluAnd = 4'h2;
    localparam alucT aluOr  = 4'h3;
    localparam alucT aluXor = 4'h4;
    localparam alucT aluSll = 4'h5;
    localparam alucT aluSrl = 4'h6;
    localparam alucT aluSra = 4'h7;
    localparam alucT aluLui = 4'hB; // Pass immediate through

    // Immediate formats
    localparam immTypeT immI = 3'h0;
    localparam immTypeT immS = 3'h1;
    localparam immTypeT immB = 3'h2;
    localparam immTypeT immU = 3'h3;
    localparam immTypeT immJ = 3'h4;

    // Resolvable branch types, MSB set
    localparam bTypeT bTypeBeq = 3'h4;
    localparam bTypeT bTypeBne = 3'h5;
    localparam bTypeT bTypeBlt = 3'h6; // Also BLTU
    localparam bTypeT bTypeBge = 3'h7; // Also BGEU

    // Forward selects
    localparam fwdSelT fwdRegFile = 2'h0;
    localparam fwdSelT fwdExeAlu  = 2'h1;
    localparam fwdSelT fwdMemAlu  = 2'h2;
    localparam fwdSelT fwdMemLoad = 2'h3;

    // Next PC selects
    localparam pcSelT pcPlus4  = 2'h0;
    localparam pcSelT pcJump   = 2'h1;
    localparam pcSelT pcBranch = 2'h2;

    // Kept opcode classes
    localparam opcodeT opRegArith = 7'b0110011;
    localparam opcodeT opImmArith = 7'b0010011;
    localparam opcodeT opBranch   = 7'b1100011;
    localparam opcodeT opLoad     = 7'b0000011;
    localparam opcodeT opStore    = 7'b0100011;
    localparam opcodeT opLui      = 7'b0110111;
    localparam opcodeT opAuipc    = 7'b0010111;
    localparam opcodeT opJal      = 7'b1101111;
    localparam opcodeT opJalr     = 7'b1100111;

    // Instruction word, laid out as in the ISA
    typedef struct packed {
        funct7T  funct7;
        regAddrT rs2;
        regAddrT rs1;
        funct3T  funct3;
        regAddrT rd;
        opcodeT  opcode;
    } instFieldsT;

    typedef struct packed {
        logic       aSel;       // ALU A: rs1 or PC
        logic [1:0] bSel;       // ALU B: rs2, imm or link
        alucT       aluc;
        logic       rSel;       // Result: ALU or comparator
        logic       signedComp;
        immTypeT    immType;
        bTypeT      bType;
        logic       isJalr;
    } exeCtrlT;

    typedef struct packed {
        logic wmem;
        logic m2reg;
        logic wreg;
    } wbCtrlT;

    // What EXE and MEM report back to ID
    typedef struct packed {
        regAddrT rd;
        logic    wreg;
        logic    m2reg;
        bTypeT   bType;
    } stageTagT;

endpackage

`default_nettype wire
